// File: bridge_params.svh
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// Bytes in one framed packet, one type byte and four payload bytes
`define BRIDGE_PKT_BYTES 5

// Packet type nibble
`define BRIDGE_BTYPE_W 4

// Device index and data index
`define BRIDGE_IDX_W 4

// Configuration command from the console
`define BRIDGE_CONF_W 16

// Command and payload word
`define BRIDGE_CMD_W 32

`endif

// File: bridge_pkg.sv
`default_nettype none

`include "bridge_params.svh"

package bridge_pkg;

    typedef logic [`BRIDGE_BTYPE_W-1:0] btype_t;
    typedef logic [`BRIDGE_IDX_W-1:0]   idx_t;
    typedef logic [`BRIDGE_CONF_W-1:0]  conf_t;
    typedef logic [`BRIDGE_CMD_W-1:0]   cmd_t;

    localparam btype_t BTYPE_INIT   = 4'd0;
    localparam btype_t BTYPE_DIDX   = 4'd5;  // Conversion request
    localparam btype_t BTYPE_DPARAM = 4'd6;  // Configuration request
    localparam btype_t BTYPE_DDIDX  = 4'd7;  // Device index answer during bring-up
    localparam btype_t BTYPE_DLINK  = 4'd8;
    localparam btype_t BTYPE_DTYPE  = 4'd9;
    localparam btype_t BTYPE_DTEMP  = 4'd10;
    localparam btype_t BTYPE_DATA0  = 4'd13;
    localparam btype_t BTYPE_DATA1  = 4'd14;

    typedef struct packed {
        btype_t btype;
        cmd_t   payload;
    } usb_pkt_t;

    typedef struct packed {
        btype_t btype;
        idx_t   data_idx;
        conf_t  conf;
    } cs_req_t;

    typedef enum logic [4:0] {
        MAIN_IDLE, MAIN_WAIT, MAIN_WORK, MAIN_READ, MAIN_TX_DONE, MAIN_RX_DONE,
        INIT_IDLE, INIT_WAIT, INIT_WORK, LINK_DONE,
        TYPE_IDLE, TYPE_WORK, TYPE_DONE,
        CONF_IDLE, CONF_SEND, CONF_READ, CONF_WAIT, CONF_DONE,
        CONV_IDLE, CONV_SEND, CONV_READ, CONV_WAIT, CONV_DONE
    } branch_state_t;

endpackage

`default_nettype wire

// File: usb_rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module usb_rx_deframer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           rx_byte,
    input  logic                 rx_valid,
    output logic                 rx_busy,
    output bridge_pkg::usb_pkt_t rx_pkt,
    output logic                 fs_usb_read,
    input  logic                 fd_usb_read
);

    localparam int unsigned LAST_BYTE = `BRIDGE_PKT_BYTES - 1;

    logic [2:0]                 byte_cnt;
    bridge_pkg::btype_t         asm_btype;
    logic [`BRIDGE_CMD_W-9:0]   asm_payload;  // Upper payload bytes seen so far
    logic                       accept;
    logic                       last;

    // Strobes are dropped while a packet is still held
    assign accept = rx_valid && !rx_busy;
    assign last   = accept && (byte_cnt == 3'(LAST_BYTE));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_cnt <= '0;
        end else if (last) begin
            byte_cnt <= '0;
        end else if (accept) begin
            byte_cnt <= byte_cnt + 3'd1;
        end
    end

    // Four-phase return toward the branch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_usb_read <= 1'b0;
            rx_busy     <= 1'b0;
        end else if (last) begin
            fs_usb_read <= 1'b1;
            rx_busy     <= 1'b1;
        end else if (fs_usb_read && fd_usb_read) begin
            fs_usb_read <= 1'b0;
        end else if (!fs_usb_read && rx_busy && !fd_usb_read) begin
            rx_busy <= 1'b0;  // Sink has dropped its done flag
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (byte_cnt == 3'd0) begin
                asm_btype <= rx_byte[`BRIDGE_BTYPE_W-1:0];  // High nibble is unused
            end else begin
                asm_payload <= {asm_payload[`BRIDGE_CMD_W-17:0], rx_byte};
            end
        end
        if (last) begin
            rx_pkt.btype   <= asm_btype;
            rx_pkt.payload <= {asm_payload, rx_byte};
        end
    end

endmodule

`default_nettype wire

// File: console_usb_branch.sv
`timescale 1ns/1ps
`default_nettype none

module console_usb_branch (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  fs_cs_send,
    output logic                  fd_cs_send,
    output logic                  fs_cs_read,
    input  logic                  fd_cs_read,
    input  bridge_pkg::cs_req_t   cs_req,
    input  bridge_pkg::btype_t    read_cs_btype,

    output logic                  fs_usb_send,
    input  logic                  fd_usb_send,
    input  logic                  fs_usb_read,
    output logic                  fd_usb_read,
    input  bridge_pkg::btype_t    read_usb_btype,

    input  bridge_pkg::idx_t      device_idx,
    output logic                  stat,
    output bridge_pkg::btype_t    send_usb_btype,
    output bridge_pkg::cmd_t      cache_cmd
);

    bridge_pkg::branch_state_t state;
    bridge_pkg::branch_state_t next_state;
    logic [1:0]                device_stat;  // Link seen, type seen

    assign stat        = &device_stat;
    assign fd_cs_send  = (state == bridge_pkg::MAIN_TX_DONE);
    assign fs_cs_read  = (state == bridge_pkg::MAIN_RX_DONE);
    assign fs_usb_send = (state == bridge_pkg::CONF_SEND) || (state == bridge_pkg::CONV_SEND) ||
                         (state == bridge_pkg::TYPE_WORK);
    assign fd_usb_read = (state == bridge_pkg::INIT_WAIT) || (state == bridge_pkg::CONF_WAIT) ||
                         (state == bridge_pkg::CONV_WAIT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= bridge_pkg::MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            bridge_pkg::MAIN_IDLE: next_state = bridge_pkg::INIT_IDLE;
            bridge_pkg::MAIN_WAIT: begin
                if (fs_cs_send) next_state = bridge_pkg::MAIN_WORK;
                else if (fs_usb_read) next_state = bridge_pkg::MAIN_READ;
            end
            bridge_pkg::MAIN_WORK: begin
                if (cs_req.btype == bridge_pkg::BTYPE_DPARAM) next_state = bridge_pkg::CONF_IDLE;
                else if (cs_req.btype == bridge_pkg::BTYPE_DIDX) next_state = bridge_pkg::CONV_IDLE;
                else next_state = bridge_pkg::MAIN_WAIT;  // Unknown request, no answer
            end
            bridge_pkg::MAIN_READ: begin
                if (read_cs_btype == bridge_pkg::BTYPE_DTEMP) next_state = bridge_pkg::CONF_READ;
                else next_state = bridge_pkg::CONV_READ;
            end
            bridge_pkg::MAIN_TX_DONE: begin
                if (!fs_cs_send) next_state = bridge_pkg::MAIN_WAIT;
            end
            bridge_pkg::MAIN_RX_DONE: begin
                if (fd_cs_read) next_state = bridge_pkg::MAIN_WAIT;
            end

            // Link bring-up with the device
            bridge_pkg::INIT_IDLE: begin
                if (fs_usb_read) next_state = bridge_pkg::INIT_WAIT;
            end
            bridge_pkg::INIT_WAIT: begin
                if (!fs_usb_read) next_state = bridge_pkg::INIT_WORK;
            end
            bridge_pkg::INIT_WORK: begin
                if (read_usb_btype == bridge_pkg::BTYPE_DLINK) next_state = bridge_pkg::LINK_DONE;
                else if (read_usb_btype == bridge_pkg::BTYPE_DTYPE) next_state = bridge_pkg::TYPE_DONE;
            end
            bridge_pkg::LINK_DONE: next_state = bridge_pkg::TYPE_IDLE;
            bridge_pkg::TYPE_IDLE: next_state = bridge_pkg::TYPE_WORK;
            bridge_pkg::TYPE_WORK: begin
                if (fd_usb_send) next_state = bridge_pkg::INIT_IDLE;  // Wait for the next packet
            end
            bridge_pkg::TYPE_DONE: next_state = bridge_pkg::MAIN_WAIT;

            bridge_pkg::CONF_IDLE: next_state = bridge_pkg::CONF_SEND;
            bridge_pkg::CONF_SEND: begin
                if (fd_usb_send) next_state = bridge_pkg::MAIN_TX_DONE;
            end
            bridge_pkg::CONF_READ: next_state = bridge_pkg::CONF_WAIT;
            bridge_pkg::CONF_WAIT: begin
                if (!fs_usb_read) next_state = bridge_pkg::CONF_DONE;
            end
            bridge_pkg::CONF_DONE: next_state = bridge_pkg::MAIN_RX_DONE;

            bridge_pkg::CONV_IDLE: next_state = bridge_pkg::CONV_SEND;
            bridge_pkg::CONV_SEND: begin
                if (fd_usb_send) next_state = bridge_pkg::MAIN_TX_DONE;
            end
            bridge_pkg::CONV_READ: begin
                // Anything other than a data packet keeps waiting
                if (read_usb_btype == bridge_pkg::BTYPE_DATA0 ||
                    read_usb_btype == bridge_pkg::BTYPE_DATA1) begin
                    next_state = bridge_pkg::CONV_WAIT;
                end
            end
            bridge_pkg::CONV_WAIT: begin
                if (!fs_usb_read) next_state = bridge_pkg::CONV_DONE;
            end
            bridge_pkg::CONV_DONE: next_state = bridge_pkg::MAIN_RX_DONE;

            default: next_state = bridge_pkg::MAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_usb_btype <= bridge_pkg::BTYPE_INIT;
        end else if (state == bridge_pkg::TYPE_IDLE) begin
            send_usb_btype <= bridge_pkg::BTYPE_DDIDX;
        end else if (state == bridge_pkg::CONF_IDLE) begin
            send_usb_btype <= bridge_pkg::BTYPE_DPARAM;
        end else if (state == bridge_pkg::CONV_IDLE) begin
            send_usb_btype <= bridge_pkg::BTYPE_DIDX;
        end
    end

    // Command word layouts for the three outbound packet kinds
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cache_cmd <= '0;
        end else if (state == bridge_pkg::TYPE_IDLE) begin
            cache_cmd <= {device_idx, 28'h0};
        end else if (state == bridge_pkg::CONF_IDLE) begin
            cache_cmd <= {device_idx, 4'h0, cs_req.conf, 8'h00};
        end else if (state == bridge_pkg::CONV_IDLE) begin
            cache_cmd <= {device_idx, cs_req.data_idx, cs_req.conf, 8'h00};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            device_stat <= 2'b00;
        end else if (state == bridge_pkg::MAIN_IDLE) begin
            device_stat <= 2'b00;
        end else if (state == bridge_pkg::LINK_DONE) begin
            device_stat[1] <= 1'b1;
        end else if (state == bridge_pkg::TYPE_DONE) begin
            device_stat[0] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: usb_tx_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module usb_tx_serializer (
    input  logic                 clk,
    input  logic                 rst,
    input  bridge_pkg::usb_pkt_t tx_pkt,
    input  logic                 fs_usb_send,
    output logic                 fd_usb_send,
    output logic [7:0]           tx_byte,
    output logic                 tx_valid
);

    localparam int unsigned LAST_BYTE = `BRIDGE_PKT_BYTES - 1;

    logic [2:0]        byte_cnt;  // Bytes still to go after the current one
    logic              busy;
    logic              start;
    bridge_pkg::cmd_t  shift_reg;

    // A request is taken only once the previous one has been fully released
    assign start = fs_usb_send && !busy && !fd_usb_send;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy        <= 1'b0;
            tx_valid    <= 1'b0;
            fd_usb_send <= 1'b0;
            byte_cnt    <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            tx_valid <= 1'b1;
            byte_cnt <= 3'(LAST_BYTE);
        end else if (busy) begin
            if (byte_cnt == 3'd0) begin
                busy        <= 1'b0;
                tx_valid    <= 1'b0;
                fd_usb_send <= 1'b1;
            end else begin
                byte_cnt <= byte_cnt - 3'd1;
            end
        end else if (fd_usb_send && !fs_usb_send) begin
            fd_usb_send <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tx_byte   <= {{(8-`BRIDGE_BTYPE_W){1'b0}}, tx_pkt.btype};
            shift_reg <= tx_pkt.payload;
        end else if (busy && byte_cnt != 3'd0) begin
            tx_byte   <= shift_reg[`BRIDGE_CMD_W-1 -: 8];  // MSB first
            shift_reg <= {shift_reg[`BRIDGE_CMD_W-9:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

// File: usb_console_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module usb_console_bridge (
    input  logic                 clk,
    input  logic                 rst,

    input  logic [7:0]           rx_byte,
    input  logic                 rx_valid,
    output logic                 rx_busy,
    output logic [7:0]           tx_byte,
    output logic                 tx_valid,

    input  logic                 fs_cs_send,
    output logic                 fd_cs_send,
    input  bridge_pkg::cs_req_t  cs_req,
    output logic                 fs_cs_read,
    input  logic                 fd_cs_read,
    output bridge_pkg::usb_pkt_t cs_read_pkt,

    input  bridge_pkg::idx_t     device_idx,
    output logic                 stat
);

    bridge_pkg::usb_pkt_t rx_pkt;
    bridge_pkg::usb_pkt_t tx_pkt;
    bridge_pkg::btype_t   send_usb_btype;
    bridge_pkg::cmd_t     cache_cmd;
    logic                 fs_usb_read;
    logic                 fd_usb_read;
    logic                 fs_usb_send;
    logic                 fd_usb_send;

    assign tx_pkt      = '{btype: send_usb_btype, payload: cache_cmd};
    assign cs_read_pkt = rx_pkt;  // Console reads the held inbound packet

    usb_rx_deframer u_rx (
        .clk         (clk),
        .rst         (rst),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .rx_busy     (rx_busy),
        .rx_pkt      (rx_pkt),
        .fs_usb_read (fs_usb_read),
        .fd_usb_read (fd_usb_read)
    );

    console_usb_branch u_branch (
        .clk            (clk),
        .rst            (rst),
        .fs_cs_send     (fs_cs_send),
        .fd_cs_send     (fd_cs_send),
        .fs_cs_read     (fs_cs_read),
        .fd_cs_read     (fd_cs_read),
        .cs_req         (cs_req),
        .read_cs_btype  (rx_pkt.btype),
        .fs_usb_send    (fs_usb_send),
        .fd_usb_send    (fd_usb_send),
        .fs_usb_read    (fs_usb_read),
        .fd_usb_read    (fd_usb_read),
        .read_usb_btype (rx_pkt.btype),
        .device_idx     (device_idx),
        .stat           (stat),
        .send_usb_btype (send_usb_btype),
        .cache_cmd      (cache_cmd)
    );

    usb_tx_serializer u_tx (
        .clk         (clk),
        .rst         (rst),
        .tx_pkt      (tx_pkt),
        .fs_usb_send (fs_usb_send),
        .fd_usb_send (fd_usb_send),
        .tx_byte     (tx_byte),
        .tx_valid    (tx_valid)
    );

endmodule

`default_nettype wire

// File: tb_usb_console_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_params.svh"

module tb_usb_console_bridge;

    localparam int NUM_OPS    = 40;
    localparam int MAX_CYCLES = 200 * (2 * NUM_OPS + 1) + 500;  // Ignored ops run two requests

    logic                 clk;
    logic                 rst;
    logic [7:0]           rx_byte;
    logic                 rx_valid;
    logic                 rx_busy;
    logic [7:0]           tx_byte;
    logic                 tx_valid;
    logic                 fs_cs_send;
    logic                 fd_cs_send;
    bridge_pkg::cs_req_t  cs_req;
    logic                 fs_cs_read;
    logic                 fd_cs_read;
    bridge_pkg::usb_pkt_t cs_read_pkt;
    bridge_pkg::idx_t     device_idx;
    logic                 stat;

    int                   cycle_cnt;
    int                   check_cnt;
    int                   err_cnt;
    bridge_pkg::usb_pkt_t out_q[$];  // Outbound packets rebuilt from tx_byte

    usb_console_bridge dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    // Cache word layouts for configuration and conversion commands
    function automatic bridge_pkg::cmd_t expected_cmd(input bridge_pkg::cs_req_t req);
        if (req.btype == bridge_pkg::BTYPE_DPARAM) begin
            return {device_idx, 4'h0, req.conf, 8'h00};
        end
        return {device_idx, req.data_idx, req.conf, 8'h00};
    endfunction

    task automatic collect_tx_bytes();
        int                   idx;
        int                   last_cycle;
        bridge_pkg::usb_pkt_t pkt;
        idx = 0;
        last_cycle = 0;
        pkt = '0;
        forever begin
            @(negedge clk);
            if (tx_valid) begin
                if (idx == 0) begin
                    check_value(64'(tx_byte[7:4]), 64'd0, "outbound type byte high nibble");
                    pkt.btype = tx_byte[3:0];
                end else begin
                    check_value(64'(cycle_cnt), 64'(last_cycle + 1), "gap between outbound bytes");
                    pkt.payload = {pkt.payload[23:0], tx_byte};
                end
                last_cycle = cycle_cnt;
                if (idx == `BRIDGE_PKT_BYTES - 1) begin
                    out_q.push_back(pkt);
                    idx = 0;
                end else begin
                    idx++;
                end
            end
        end
    endtask

    // Device side framing, one byte per cycle unless the deframer is busy
    task automatic frame_device_pkt(input bridge_pkg::btype_t btype,
                                    input bridge_pkg::cmd_t payload);
        logic [7:0] pkt_bytes [`BRIDGE_PKT_BYTES];
        int         i;
        pkt_bytes[0] = {4'h0, btype};
        for (i = 1; i < `BRIDGE_PKT_BYTES; i++) begin
            pkt_bytes[i] = payload[8*(`BRIDGE_PKT_BYTES-1-i) +: 8];
        end
        for (i = 0; i < `BRIDGE_PKT_BYTES; i++) begin
            while (rx_busy) @(negedge clk);
            rx_byte  = pkt_bytes[i];
            rx_valid = 1'b1;
            @(negedge clk);
        end
        rx_valid = 1'b0;
    endtask

    task automatic device_read(input bridge_pkg::btype_t btype);
        bridge_pkg::usb_pkt_t exp_pkt;
        exp_pkt.btype   = btype;
        exp_pkt.payload = $urandom;
        frame_device_pkt(exp_pkt.btype, exp_pkt.payload);
        while (!fs_cs_read) @(negedge clk);
        check_value(64'(cs_read_pkt), 64'(exp_pkt), "console read packet");
        fd_cs_read = 1'b1;
        @(negedge clk);
        while (fs_cs_read) @(negedge clk);
        fd_cs_read = 1'b0;
        check_value(64'(out_q.size()), 64'd0, "outbound packets during a read");
    endtask

    task automatic console_request(input bridge_pkg::btype_t btype);
        bridge_pkg::usb_pkt_t got;
        logic                 valid_type;
        valid_type = (btype == bridge_pkg::BTYPE_DPARAM) || (btype == bridge_pkg::BTYPE_DIDX);
        cs_req     = '{btype: btype, data_idx: 4'($urandom), conf: 16'($urandom)};
        fs_cs_send = 1'b1;
        if (valid_type) begin
            @(negedge clk);
            while (!fd_cs_send) @(negedge clk);
            check_value(64'(out_q.size()), 64'd1, "outbound packets per request");
            if (out_q.size() != 0) begin
                got = out_q.pop_front();
                check_value(64'(got), 64'({btype, expected_cmd(cs_req)}), "outbound packet");
            end
            fs_cs_send = 1'b0;
            @(negedge clk);
            while (fd_cs_send) @(negedge clk);
        end else begin
            repeat (16) begin  // No answer is expected, so hold for a while
                @(negedge clk);
                check_value(64'({fd_cs_send, tx_valid}), 64'd0, "response to an ignored request");
            end
            fs_cs_send = 1'b0;
            repeat (4) @(negedge clk);
        end
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        bridge_pkg::btype_t   btype;
        bridge_pkg::usb_pkt_t got;
        int                   n;
        rst        = 1'b1;
        rx_byte    = '0;
        rx_valid   = 1'b0;
        fs_cs_send = 1'b0;
        cs_req     = '0;
        fd_cs_read = 1'b0;
        device_idx = '0;
        check_cnt  = 0;
        err_cnt    = 0;
        void'($urandom(32'h73d5524d));
        device_idx = 4'($urandom);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            collect_tx_bytes();
        join_none
        @(negedge clk);
        check_value(64'({stat, tx_valid, rx_busy, fd_cs_send, fs_cs_read}), 64'd0,
                    "outputs after reset");

        // Link bring-up, the device answers DTYPE only after the DDIDX packet
        frame_device_pkt(bridge_pkg::BTYPE_DLINK, $urandom);
        while (out_q.size() == 0) @(negedge clk);
        repeat (20) @(negedge clk);
        check_value(64'(out_q.size()), 64'd1, "DDIDX packets after DLINK");
        if (out_q.size() != 0) begin
            got = out_q.pop_front();
            check_value(64'(got), 64'({bridge_pkg::BTYPE_DDIDX, device_idx, 28'h0}),
                        "DDIDX packet");
        end
        check_value(64'(stat), 64'd0, "stat before DTYPE");
        frame_device_pkt(bridge_pkg::BTYPE_DTYPE, $urandom);
        while (!stat) @(negedge clk);
        repeat (20) @(negedge clk);
        check_value(64'(out_q.size()), 64'd0, "outbound packets after DTYPE");

        for (n = 0; n < NUM_OPS; n++) begin
            case ($urandom % 5)
                0: console_request(bridge_pkg::BTYPE_DPARAM);
                1: console_request(bridge_pkg::BTYPE_DIDX);
                2: device_read(bridge_pkg::BTYPE_DTEMP);
                3: device_read(($urandom % 2 == 0) ? bridge_pkg::BTYPE_DATA0 :
                                                     bridge_pkg::BTYPE_DATA1);
                default: begin
                    btype = 4'($urandom);
                    btype = (btype == bridge_pkg::BTYPE_DPARAM || btype == bridge_pkg::BTYPE_DIDX) ?
                            bridge_pkg::BTYPE_INIT : btype;
                    console_request(btype);
                    console_request(($urandom % 2 == 0) ? bridge_pkg::BTYPE_DPARAM :
                                                          bridge_pkg::BTYPE_DIDX);
                end
            endcase
        end

        repeat (10) @(negedge clk);
        check_value(64'(out_q.size()), 64'd0, "outbound packets left at the end");
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
bridge_pkg.sv
usb_rx_deframer.sv
console_usb_branch.sv
usb_tx_serializer.sv
usb_console_bridge.sv
tb_usb_console_bridge.sv

// File: Makefile
TOP := tb_usb_console_bridge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

lint:
	verilator --lint-only -Wall -f vlog.f --top-module usb_console_bridge

clean:
	rm -rf obj_dir sim.log
